/* core_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module core_fetch
(
	input  logic                clk,
	                            arst_n,
	                            branch,
	input  core_pkg::ptr        branch_target,
	input  logic                pop,

	output core_pkg::fetch_out_t head,
	output logic                head_valid,

	output logic                insn_start,
	output core_pkg::ptr        insn_addr,
	input  logic                insn_ready,
	input  core_pkg::word       insn_data_rd
);

	core_pkg::fetch_out_t queue[core_pkg::PREFETCH_DEPTH];

	logic [core_pkg::PREFETCH_ORDER-1:0] rd_ptr, wr_ptr;
	logic [core_pkg::PREFETCH_ORDER:0] count;

	core_pkg::ptr fetch_head;
	logic outstanding, stale;
	logic issue, push, take;

	// Only one fetch in flight, so a free slot is reserved for its response.
	assign issue = !outstanding && !insn_start && !branch
	               && count < core_pkg::PREFETCH_DEPTH;

	assign push = insn_ready && !stale && !branch; // Old-path data is dropped.
	assign take = pop && head_valid && !branch;

	assign head = queue[rd_ptr];
	assign head_valid = count != '0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			insn_start <= 1'b0;
			outstanding <= 1'b0;
			stale <= 1'b0;
			fetch_head <= core_pkg::RESET_PC;
		end else begin
			insn_start <= issue;

			if (insn_start)
				outstanding <= 1'b1;
			else if (insn_ready)
				outstanding <= 1'b0;

			if (branch)
				stale <= (outstanding && !insn_ready) || insn_start;
			else if (insn_ready)
				stale <= 1'b0;

			if (branch)
				fetch_head <= branch_target;
			else if (issue)
				fetch_head <= fetch_head + 30'd1;
		end
	end

	always_ff @(posedge clk)
		if (issue)
			insn_addr <= fetch_head; // Held stable until the next issue.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else if (branch) begin
			rd_ptr <= '0; // Flush.
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;

			if (take)
				rd_ptr <= rd_ptr + 1'b1;

			case ({push, take})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk)
		if (push)
			queue[wr_ptr] <= '{pc: insn_addr, insn: insn_data_rd};

	// Only one fetch is in flight and it is answered only after it was started.
	a_single_fetch: assert property (@(posedge clk) disable iff (!arst_n)
		insn_start |-> !outstanding);

	a_ready_owned: assert property (@(posedge clk) disable iff (!arst_n)
		insn_ready |-> outstanding);

	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		push |-> count < core_pkg::PREFETCH_DEPTH);

endmodule

`default_nettype wire

/* core_mem_front.sv */
`timescale 1ns/10ps
`default_nettype none

module core_mem_front
(
	input  logic                clk,
	                            arst_n,
	                            branch,
	input  core_pkg::ptr        branch_target,
	input  logic                stall,

	input  logic                data_start,
	input  core_pkg::mem_req_t  data_req,
	output logic                data_ready,
	output core_pkg::word       data_data_rd,

	output core_pkg::fetch_out_t insn,
	output logic                insn_valid,

	output logic                bus_start,
	output core_pkg::mem_req_t  bus_req,
	input  logic                bus_ready,
	input  core_pkg::word       bus_data_rd
);

	core_pkg::fetch_out_t head;
	logic head_valid, pop;

	core_pkg::ptr insn_addr;
	core_pkg::word insn_data_rd;
	logic insn_start, insn_ready;

	core_fetch fetch
	(
		.*
	);

	core_porch porch
	(
		.*
	);

	core_mmu mmu
	(
		.*
	);

endmodule

`default_nettype wire

/* core_mmu.sv */
`timescale 1ns/10ps
`default_nettype none

module core_mmu
(
	input  logic              clk,
	                          arst_n,

	input  logic              data_start,
	input  core_pkg::mem_req_t data_req,
	output logic              data_ready,
	output core_pkg::word     data_data_rd,

	input  logic              insn_start,
	input  core_pkg::ptr      insn_addr,
	output logic              insn_ready,
	output core_pkg::word     insn_data_rd,

	output logic              bus_start,
	output core_pkg::mem_req_t bus_req,
	input  logic              bus_ready,
	input  core_pkg::word     bus_data_rd
);

	core_pkg::mem_req_t data_req_q, data_cur;
	core_pkg::ptr insn_addr_q, insn_cur;

	logic data_pend, insn_pend, data_want, insn_want;
	logic busy, free, grant_data, grant_insn, owner_data;
	logic data_open, insn_open;

	assign data_want = data_start || data_pend;
	assign insn_want = insn_start || insn_pend;
	assign data_cur = data_start ? data_req : data_req_q;
	assign insn_cur = insn_start ? insn_addr : insn_addr_q;

	assign free = !busy || bus_ready; // Bus frees on its last cycle.
	assign grant_data = free && data_want;
	assign grant_insn = free && !data_want && insn_want; // Data wins.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data_pend <= 1'b0;
			insn_pend <= 1'b0;
			busy <= 1'b0;
			owner_data <= 1'b0;
			bus_start <= 1'b0;
			data_ready <= 1'b0;
			insn_ready <= 1'b0;
			data_open <= 1'b0;
			insn_open <= 1'b0;
		end else begin
			data_pend <= data_want && !grant_data;
			insn_pend <= insn_want && !grant_insn;

			bus_start <= grant_data || grant_insn;
			busy <= grant_data || grant_insn || (busy && !bus_ready);
			if (grant_data || grant_insn)
				owner_data <= grant_data;

			data_ready <= bus_ready && owner_data;
			insn_ready <= bus_ready && !owner_data;

			data_open <= data_start || (data_open && !data_ready);
			insn_open <= insn_start || (insn_open && !insn_ready);
		end
	end

	always_ff @(posedge clk) begin
		if (data_start)
			data_req_q <= data_req;

		if (insn_start)
			insn_addr_q <= insn_addr;

		if (grant_data)
			bus_req <= data_cur;
		else if (grant_insn)
			bus_req <= '{addr: insn_cur, write: 1'b0, data: '0};

		if (bus_ready) begin
			data_data_rd <= bus_data_rd; // Only the owner sees ready.
			insn_data_rd <= bus_data_rd;
		end
	end

	a_bus_ready_busy: assert property (@(posedge clk) disable iff (!arst_n)
		bus_ready |-> busy && !bus_start);

	a_data_one_open: assert property (@(posedge clk) disable iff (!arst_n)
		data_start |-> !data_open);

	a_insn_one_open: assert property (@(posedge clk) disable iff (!arst_n)
		insn_start |-> !insn_open);

endmodule

`default_nettype wire

/* core_pkg.sv */
`default_nettype none

package core_pkg;

	typedef logic [31:0] word;
	typedef logic [29:0] ptr; // Word address taken from byte address bits 31:2.

	typedef struct packed {
		ptr   addr;
		logic write;
		word  data;
	} mem_req_t;

	typedef struct packed {
		ptr  pc;
		word insn;
	} fetch_out_t;

	localparam int PREFETCH_ORDER = 2;
	localparam int PREFETCH_DEPTH = 1 << PREFETCH_ORDER;

	localparam ptr RESET_PC = 30'd0; // First fetch address.

endpackage

`default_nettype wire

/* core_porch.sv */
`timescale 1ns/10ps
`default_nettype none

module core_porch
(
	input  logic                clk,
	                            arst_n,
	                            stall,
	                            branch,

	input  core_pkg::fetch_out_t head,
	input  logic                head_valid,
	output logic                pop,

	output core_pkg::fetch_out_t insn,
	output logic                insn_valid
);

	// Take the queue head whenever decode is free to move on.
	assign pop = !stall && !branch && head_valid;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			insn_valid <= 1'b0;
		else if (branch)
			insn_valid <= 1'b0; // Old path is dead.
		else if (!stall)
			insn_valid <= head_valid;
	end

	always_ff @(posedge clk)
		if (pop)
			insn <= head;

endmodule

`default_nettype wire

/* files.f */
core_pkg.sv
core_fetch.sv
core_mmu.sv
core_porch.sv
core_mem_front.sv
tb_core_mem_front.sv

/* mem_front_golden.txt */
// Columns: op addr value, all hex, addr is a word address.
// op 1 image word, 2 data read (value expected), 3 data write, 4 branch to addr,
// op 5 stall for value cycles, 6 run for value cycles, 0 end of list.
1 004 e3a01005
1 005 e2811001
1 200 11223344
1 201 a5a5f00f
1 202 deadbeef
1 203 0badcafe
6 0 c
2 200 11223344
2 201 a5a5f00f
5 0 10
2 202 deadbeef
3 204 cafef00d
2 204 cafef00d
3 300 e1a00000
3 301 e0802001
4 300 0
6 0 14
2 203 0badcafe
4 100 0
2 201 a5a5f00f
3 205 12345678
2 205 12345678
5 0 8
4 40 0
4 48 0
6 0 18
3 200 55aa55aa
2 200 55aa55aa
6 0 a
0 0 0

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; a $fatal gives a non-zero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_core_mem_front \
	-f files.f \
	-o sim_mem_front

./obj_dir/sim_mem_front

/* tb_core_mem_front.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_core_mem_front;

	localparam int MEM_BITS = 10;
	localparam int GOLDEN_WORDS = 3 * 64; // Three columns per step.
	localparam int STEP_CYCLES = 40;

	logic clk, arst_n, branch, stall, data_start, bus_ready;
	core_pkg::ptr branch_target;
	core_pkg::mem_req_t data_req, bus_req;
	core_pkg::word data_data_rd, bus_data_rd;
	core_pkg::fetch_out_t insn;
	logic data_ready, insn_valid, bus_start;

	core_pkg::word mem[0:(1 << MEM_BITS) - 1];
	logic [31:0] golden[0:GOLDEN_WORDS - 1];

	int i, step_count, issued, lat;
	int watch_cycles = 0;
	logic [31:0] seed;
	logic live;

	logic mon_live, mon_stall, mon_branch, last_valid;
	core_pkg::ptr mon_target, exp_pc;
	core_pkg::fetch_out_t last_insn, exp_insn;

	core_mem_front DUT (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_run;
		$display("Test failures found");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_error(input string why);
		$display("%0t ns: %s", $time, why);
		stop_run();
	endtask

	task automatic check_word(input string name, input core_pkg::word expected,
	                          input core_pkg::word actual);
		if (actual !== expected) begin
			$display("[FAIL] time=%0t signal=%s expected=%h actual=%h",
			         $time, name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_fetch(input string name, input core_pkg::fetch_out_t expected,
	                           input core_pkg::fetch_out_t actual);
		if (actual !== expected) begin
			$display("[FAIL] time=%0t signal=%s expected pc=%h insn=%h actual pc=%h insn=%h",
			         $time, name, expected.pc, expected.insn, actual.pc, actual.insn);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[FAIL] time=%0t signal=%s expected=%b actual=%b",
			         $time, name, expected, actual);
			stop_run();
		end
	endtask

	function automatic core_pkg::word fill_word(input int unsigned a);
		return 32'he1a0_0000 ^ (a * 32'h0001_0101);
	endfunction

	function automatic core_pkg::word mem_read(input core_pkg::ptr a);
		return mem[a[MEM_BITS-1:0]];
	endfunction

	task automatic data_access(input logic write, input core_pkg::ptr addr,
	                           input core_pkg::word value);
		@(posedge clk);
		#1;
		data_start = 1'b1;
		data_req.addr = addr;
		data_req.write = write;
		data_req.data = write ? value : '0;
		@(posedge clk);
		#1;
		data_start = 1'b0;
		data_req = '0;
		@(negedge clk);
		while (!data_ready)
			@(negedge clk);
		if (!write)
			check_word("data_data_rd", value, data_data_rd);
	endtask

	task automatic take_branch(input core_pkg::ptr target);
		@(posedge clk);
		#1;
		branch = 1'b1;
		branch_target = target;
		@(posedge clk);
		#1;
		branch = 1'b0;
	endtask

	task automatic stall_window(input int cycles);
		@(posedge clk);
		#1;
		stall = 1'b1;
		repeat (cycles) @(posedge clk);
		#1;
		stall = 1'b0;
	endtask

	task automatic run_step(input logic [31:0] op, input logic [31:0] addr,
	                        input logic [31:0] value);
		case (op)
			32'd1: ; // Image words are loaded before reset.
			32'd2: data_access(1'b0, addr[29:0], value);
			32'd3: data_access(1'b1, addr[29:0], value);
			32'd4: take_branch(addr[29:0]);
			32'd5: stall_window(value);
			32'd6: repeat (value) @(posedge clk);
			default: report_error($sformatf("unknown step code %0h in the golden file", op));
		endcase
	endtask

	// Bus memory model with a random latency of 1 to 4 cycles.
	initial begin
		forever begin
			@(negedge clk);
			if (bus_start) begin
				if (bus_req.addr >= (1 << MEM_BITS))
					report_error("bus address lies outside the memory model");
				lat = $urandom % 4 + 1;
				repeat (lat) @(posedge clk);
				#1;
				bus_ready = 1'b1;
				if (bus_req.write)
					mem[bus_req.addr[MEM_BITS-1:0]] = bus_req.data;
				else
					bus_data_rd = mem[bus_req.addr[MEM_BITS-1:0]];
				@(posedge clk);
				#1;
				bus_ready = 1'b0;
			end
		end
	end

	// Follows every porch update against the expected program order.
	initial begin
		forever begin
			@(posedge clk);
			mon_live = live;
			mon_stall = stall;
			mon_branch = branch;
			mon_target = branch_target;
			@(negedge clk);
			if (mon_live && mon_branch) begin
				check_bit("insn_valid", 1'b0, insn_valid);
				exp_pc = mon_target;
			end else if (mon_live && mon_stall) begin
				check_bit("insn_valid", last_valid, insn_valid);
				check_fetch("insn", last_insn, insn);
			end else if (mon_live && insn_valid) begin
				exp_insn.pc = exp_pc;
				exp_insn.insn = mem_read(exp_pc);
				check_fetch("insn", exp_insn, insn);
				exp_pc = exp_pc + 30'd1;
				issued++;
			end
			last_valid = insn_valid;
			last_insn = insn;
		end
	end

	initial begin
		wait (watch_cycles != 0);
		repeat (watch_cycles) @(posedge clk);
		$display("Timeout: the run went past %0d cycles without finishing", watch_cycles);
		stop_run();
	end

	initial begin
		seed = $urandom(32'h4d69);
		arst_n = 1'b0;
		branch = 1'b0;
		branch_target = '0;
		stall = 1'b0;
		data_start = 1'b0;
		data_req = '0;
		bus_ready = 1'b0;
		bus_data_rd = '0;
		live = 1'b0;
		issued = 0;
		exp_pc = core_pkg::RESET_PC;

		for (i = 0; i < (1 << MEM_BITS); i++)
			mem[i] = fill_word(i);
		for (i = 0; i < GOLDEN_WORDS; i++)
			golden[i] = '0;
		$readmemh("mem_front_golden.txt", golden);

		step_count = 0;
		for (i = 0; i < GOLDEN_WORDS; i += 3) begin
			if (golden[i] == 32'd1)
				mem[golden[i+1][MEM_BITS-1:0]] = golden[i+2];
			else if (golden[i] != 32'd0)
				step_count++;
		end
		if (step_count == 0)
			report_error("no steps were read from mem_front_golden.txt");
		watch_cycles = (step_count + 1) * STEP_CYCLES;

		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;
		live = 1'b1;

		// First bus request two cycles after reset release.
		@(negedge clk);
		check_bit("insn_valid", 1'b0, insn_valid);
		check_bit("data_ready", 1'b0, data_ready);
		check_bit("bus_start", 1'b0, bus_start);
		@(negedge clk);
		check_bit("bus_start", 1'b0, bus_start);
		@(negedge clk);
		check_bit("bus_start", 1'b1, bus_start);

		i = 0;
		while (i < GOLDEN_WORDS && golden[i] != 32'd0) begin
			run_step(golden[i], golden[i+1], golden[i+2]);
			i += 3;
		end

		if (issued == 0) begin
			report_error("no instruction reached the decode side");
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

`default_nettype wire
